/* sim.f */
sprVideoPkg.sv
sprRegPkg.sv
sprAttrIf.sv
sprTimingRef.sv
sprRegFile.sv
sprImageRam.sv
sprScanner.sv
sprCompositor.sv
spriteCtrl.sv
tbSpriteCtrl.sv

/* sprAttrIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface sprAttrIf;
	import sprVideoPkg::*;
	import sprRegPkg::*;

	// position, in hctr and vctr units
	hCount_t hPos;
	vCount_t vPos;
	// size in image pixels, minus one
	sprDim_t width;
	sprDim_t height;
	// pixel stretch, minus one
	pixRes_t hRes;
	pixRes_t vRes;
	// output plane, transparent color and enable
	plane_t plane;
	tColor_t tc;
	logic en;

	modport regs (output hPos, vPos, width, height, hRes, vRes, plane, tc, en);
	// the scanner only needs geometry
	modport scan (input hPos, vPos, width, height, hRes, vRes);
	// the compositor only needs the output attributes
	modport comp (input plane, tc, en);

endinterface

`default_nettype wire

/* sprCompositor.sv */
`timescale 1ns/10ps
`default_nettype none

module sprCompositor #(
	parameter int NSPR = 4
) (
	input wire logic vclk,
	input wire logic rst_i,
	input wire sprVideoPkg::sprPixel_t sprPix_i [NSPR],
	input wire logic [NSPR-1:0] sprDe_i,
	sprAttrIf.comp attr [NSPR],
	input wire sprVideoPkg::zrgb_t zrgb_i,
	input wire logic blank_i,
	output sprVideoPkg::zrgb_t zrgb_o
);
	import sprVideoPkg::*;

	// the output register is the last stage of the delay
	localparam int ZDLY = PIPE_DLY - 1;

	zrgb_t zDly [ZDLY];
	logic [ZDLY-1:0] blankDly;
	logic [ZDLY-1:0] vldDly;
	logic [NSPR-1:0] act;
	plane_t sprPlane [NSPR];
	sprPixel_t winPixC;
	plane_t winPlaneC;
	sprPixel_t winPix;
	plane_t winPlane;
	logic winAct;
	zrgb_t zIn;
	logic blankIn;

	// opaque pixel of an enabled sprite inside its rectangle
	for (genvar g = 0; g < NSPR; g++) begin : gAct
		assign act[g] = attr[g].en && sprDe_i[g] && (sprPix_i[g][14:0] != attr[g].tc);
		assign sprPlane[g] = attr[g].plane;
	end

	// lowest numbered active sprite wins
	always_comb begin
		winPixC = sprPix_i[0];
		winPlaneC = sprPlane[0];
		for (int i = NSPR - 1; i >= 0; i--) begin
			if (act[i]) begin
				winPixC = sprPix_i[i];
				winPlaneC = sprPlane[i];
			end
		end
	end

	// --------------------
	// stage 1
	// --------------------
	always_ff @(posedge vclk) begin
		if (rst_i)
			winAct <= 1'b0;
		else
			winAct <= |act;
	end

	always_ff @(posedge vclk) begin
		winPix <= winPixC;
		winPlane <= winPlaneC;
	end

	// input stream delay, matched to the sprite path
	always_ff @(posedge vclk) begin
		zDly[0] <= zrgb_i;
		blankDly[0] <= blank_i;
		for (int i = 1; i < ZDLY; i++) begin
			zDly[i] <= zDly[i-1];
			blankDly[i] <= blankDly[i-1];
		end
	end

	// marks delay stages that hold real input since reset
	always_ff @(posedge vclk) begin
		if (rst_i)
			vldDly <= '0;
		else
			vldDly <= ZDLY'({vldDly, 1'b1});
	end

	assign zIn = zDly[ZDLY-1];
	assign blankIn = blankDly[ZDLY-1];

	// --------------------
	// stage 2
	// --------------------
	always_ff @(posedge vclk) begin
		if (rst_i)
			zrgb_o <= '0;
		else if (!vldDly[ZDLY-1] || blankIn)
			zrgb_o <= '0;
		else if (!winAct || zIn[39:36] > winPlane)
			zrgb_o <= zIn;
		else
			// 5-bit components go to the top of each 12-bit field
			zrgb_o <= {winPlane, winPix[14:10], 7'b0, winPix[9:5], 7'b0, winPix[4:0], 7'b0};
	end

endmodule

`default_nettype wire

/* sprImageRam.sv */
`timescale 1ns/10ps
`default_nettype none

module sprImageRam (
	input wire logic vclk,
	input wire logic wrEn_i,
	input wire sprVideoPkg::imgAdr_t wrAdr_i,
	input wire sprVideoPkg::sprPixel_t wrDat_i,
	input wire sprVideoPkg::imgAdr_t rdAdr_i,
	output sprVideoPkg::sprPixel_t rdDat_o
);
	import sprVideoPkg::*;

	// 256 x 16 image store
	sprPixel_t mem [256];

	// load port
	always_ff @(posedge vclk) begin
		if (wrEn_i)
			mem[wrAdr_i] <= wrDat_i;
	end

	// display port, data one cycle after the address
	// a read at the address being loaded returns the old pixel
	always_ff @(posedge vclk) begin
		rdDat_o <= mem[rdAdr_i];
	end

endmodule

`default_nettype wire

/* sprRegFile.sv */
`timescale 1ns/10ps
`default_nettype none

module sprRegFile #(
	parameter int NSPR = 4
) (
	input wire logic vclk,
	input wire logic rst_i,
	input wire logic regWr_i,
	input wire sprRegPkg::regAdr_t regAdr_i,
	input wire sprRegPkg::regData_t regDat_i,
	sprAttrIf.regs attr [NSPR]
);
	import sprRegPkg::*;

	// word index split into sprite number and offset in its block
	logic [5:0] sprN;
	logic [1:0] offs;
	logic enWr;

	assign sprN = regAdr_i[7:2];
	assign offs = regAdr_i[1:0];
	// REG_EN decodes to sprite 60, so it never aliases a sprite block
	assign enWr = regWr_i && (regAdr_i == REG_EN);

	// --------------------
	// per-sprite registers
	// --------------------
	for (genvar g = 0; g < NSPR; g++) begin : gSpr
		logic sel;

		assign sel = regWr_i && (sprN == 6'(g));

		always_ff @(posedge vclk) begin
			if (rst_i) begin
				attr[g].hPos <= '0;
				attr[g].vPos <= '0;
				attr[g].width <= '0;
				attr[g].height <= '0;
				attr[g].hRes <= '0;
				attr[g].vRes <= '0;
				attr[g].plane <= '0;
				attr[g].tc <= '0;
				attr[g].en <= 1'b0;
			end else begin
				// position word
				if (sel && offs == REG_POS) begin
					attr[g].hPos <= regDat_i[11:0];
					attr[g].vPos <= regDat_i[27:16];
				end
				// size word, also carries stretch and plane
				if (sel && offs == REG_SIZE) begin
					attr[g].width <= regDat_i[7:0];
					attr[g].height <= regDat_i[15:8];
					attr[g].hRes <= regDat_i[19:16];
					attr[g].vRes <= regDat_i[23:20];
					attr[g].plane <= regDat_i[27:24];
				end
				if (sel && offs == REG_TC)
					attr[g].tc <= regDat_i[14:0];
				// each sprite takes its own bit of the global enable
				if (enWr)
					attr[g].en <= regDat_i[g];
			end
		end
	end

endmodule

`default_nettype wire

/* sprRegPkg.sv */
`default_nettype none

package sprRegPkg;

	// whole 32-bit words, addressed by word index
	typedef logic [7:0] regAdr_t;
	typedef logic [31:0] regData_t;

	// --------------------
	// register map
	// --------------------

	// sprite n owns words 4n to 4n+3
	localparam logic [1:0] REG_POS = 2'd0;
	localparam logic [1:0] REG_SIZE = 2'd1;
	localparam logic [1:0] REG_TC = 2'd2;
	// offset 3 is left free

	// global enable, bit n for sprite n
	localparam regAdr_t REG_EN = 8'd240;

	// --------------------
	// field types
	// --------------------

	// width or height minus one
	typedef logic [7:0] sprDim_t;
	// stretch in video clocks minus one
	typedef logic [3:0] pixRes_t;
	// transparent color, rgb 5:5:5
	typedef logic [14:0] tColor_t;

endpackage

`default_nettype wire

/* sprScanner.sv */
`timescale 1ns/10ps
`default_nettype none

module sprScanner (
	input wire logic vclk,
	input wire logic rst_i,
	input wire sprVideoPkg::hCount_t hctr_i,
	input wire sprVideoPkg::vCount_t vctr_i,
	input wire logic hEdge_i,
	input wire logic vEdge_i,
	sprAttrIf.scan attr,
	input wire logic imgWr_i,
	input wire sprVideoPkg::imgAdr_t imgAdr_i,
	input wire sprVideoPkg::sprPixel_t imgDat_i,
	output sprVideoPkg::sprPixel_t sprPix_o,
	output logic sprDe_o
);
	import sprVideoPkg::*;
	import sprRegPkg::*;

	logic hRst;
	logic vRst;
	logic hNext;
	logic vNext;
	// stretch counters, column and row counters
	pixRes_t hPt;
	pixRes_t vPt;
	sprDim_t hCnt;
	sprDim_t vCnt;
	logic hDe;
	logic vDe;
	// current image index and start of the row being rescanned
	imgAdr_t sprAdr;
	imgAdr_t sprAdrB;

	// left column and top row of the sprite
	assign hRst = (hctr_i == attr.hPos);
	assign vRst = (vctr_i == attr.vPos);
	// last clock of a stretched pixel or line
	assign hNext = (hPt == attr.hRes);
	assign vNext = (vPt == attr.vRes);

	// --------------------
	// horizontal
	// --------------------
	// registered state describes the dot of the previous cycle's hctr
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hPt <= '0;
			hCnt <= '0;
			hDe <= 1'b0;
		end else if (hRst) begin
			hPt <= '0;
			hCnt <= '0;
			hDe <= 1'b1;
		end else if (hEdge_i) begin
			// a sprite past the line end is cut, not wrapped
			hDe <= 1'b0;
		end else if (hDe) begin
			if (hNext) begin
				hPt <= '0;
				hCnt <= hCnt + 1'b1;
				if (hCnt == attr.width)
					hDe <= 1'b0;
			end else begin
				hPt <= hPt + 1'b1;
			end
		end
	end

	// --------------------
	// vertical
	// --------------------
	// steps once per line, at the sprite's left column
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			vPt <= '0;
			vCnt <= '0;
			vDe <= 1'b0;
		end else if (hRst && vRst) begin
			vPt <= '0;
			vCnt <= '0;
			vDe <= 1'b1;
		end else if (vEdge_i) begin
			vDe <= 1'b0;
		end else if (hRst && vDe) begin
			if (vNext) begin
				vPt <= '0;
				vCnt <= vCnt + 1'b1;
				if (vCnt == attr.height)
					vDe <= 1'b0;
			end else begin
				vPt <= vPt + 1'b1;
			end
		end
	end

	// image address, row * (width + 1) + column
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			sprAdr <= '0;
			sprAdrB <= '0;
		end else if (hRst && vRst) begin
			sprAdr <= '0;
			sprAdrB <= '0;
		end else if (hRst) begin
			// the previous row ended one past its last pixel
			if (vNext)
				sprAdrB <= sprAdr;
			else
				sprAdr <= sprAdrB;
		end else if (hDe && hNext) begin
			sprAdr <= sprAdr + 1'b1;
		end
	end

	sprImageRam uRam (
		.vclk(vclk),
		.wrEn_i(imgWr_i),
		.wrAdr_i(imgAdr_i),
		.wrDat_i(imgDat_i),
		.rdAdr_i(sprAdr),
		.rdDat_o(sprPix_o)
	);

	// display enable follows the RAM read by one cycle
	always_ff @(posedge vclk) begin
		if (rst_i)
			sprDe_o <= 1'b0;
		else
			sprDe_o <= hDe & vDe;
	end

endmodule

`default_nettype wire

/* sprTimingRef.sv */
`timescale 1ns/10ps
`default_nettype none

module sprTimingRef (
	input wire logic vclk,
	input wire logic rst_i,
	input wire logic hsync_i,
	input wire logic vsync_i,
	output sprVideoPkg::hCount_t hctr_o,
	output sprVideoPkg::vCount_t vctr_o,
	output logic hEdge_o,
	output logic vEdge_o
);
	// sync levels from the previous cycle
	logic hsPrev;
	logic vsPrev;
	logic hRise;
	logic vRise;

	assign hRise = hsync_i & ~hsPrev;
	assign vRise = vsync_i & ~vsPrev;

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hsPrev <= 1'b0;
			vsPrev <= 1'b0;
			hEdge_o <= 1'b0;
			vEdge_o <= 1'b0;
			hctr_o <= '0;
			vctr_o <= '0;
		end else begin
			hsPrev <= hsync_i;
			vsPrev <= vsync_i;
			// edge pulses line up with the cycle where the counter is zero
			hEdge_o <= hRise;
			vEdge_o <= vRise;
			// dot counter restarts on every hsync edge
			if (hRise)
				hctr_o <= '0;
			else
				hctr_o <= hctr_o + 1'b1;
			// line counter, vsync takes priority
			if (vRise)
				vctr_o <= '0;
			else if (hRise)
				vctr_o <= vctr_o + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* sprVideoPkg.sv */
`default_nettype none

package sprVideoPkg;

	// --------------------
	// reference counters
	// --------------------

	// dots since the hsync rising edge
	typedef logic [11:0] hCount_t;
	// lines since the vsync rising edge
	typedef logic [11:0] vCount_t;

	// --------------------
	// pixel formats
	// --------------------

	// stream word: plane in 39:36, then 12-bit red, green and blue
	typedef logic [39:0] zrgb_t;
	typedef logic [3:0] plane_t;

	// stored sprite pixel, rgb 5:5:5 in 14:0, bit 15 unused
	typedef logic [15:0] sprPixel_t;

	// one sprite image holds 256 pixels
	typedef logic [7:0] imgAdr_t;

	// cycles from zrgb_i to zrgb_o
	localparam int PIPE_DLY = 4;

endpackage

`default_nettype wire

/* spriteCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module spriteCtrl #(
	parameter int NSPR = 4
) (
	input wire logic vclk,
	input wire logic rst_i,
	// register writes
	input wire logic regWr_i,
	input wire sprRegPkg::regAdr_t regAdr_i,
	input wire sprRegPkg::regData_t regDat_i,
	// image load, sprite select covers up to 32 sprites
	input wire logic imgWr_i,
	input wire logic [4:0] imgSpr_i,
	input wire sprVideoPkg::imgAdr_t imgAdr_i,
	input wire sprVideoPkg::sprPixel_t imgDat_i,
	// video stream
	input wire logic hsync_i,
	input wire logic vsync_i,
	input wire logic blank_i,
	input wire sprVideoPkg::zrgb_t zrgb_i,
	output sprVideoPkg::zrgb_t zrgb_o
);
	import sprVideoPkg::*;

	wire hCount_t hctr;
	wire vCount_t vctr;
	wire logic hEdge;
	wire logic vEdge;
	wire sprPixel_t sprPix [NSPR];
	wire logic [NSPR-1:0] sprDe;

	sprAttrIf attr [NSPR] ();

	sprTimingRef uTiming (
		.vclk(vclk),
		.rst_i(rst_i),
		.hsync_i(hsync_i),
		.vsync_i(vsync_i),
		.hctr_o(hctr),
		.vctr_o(vctr),
		.hEdge_o(hEdge),
		.vEdge_o(vEdge)
	);

	sprRegFile #(.NSPR(NSPR)) uRegs (
		.vclk(vclk),
		.rst_i(rst_i),
		.regWr_i(regWr_i),
		.regAdr_i(regAdr_i),
		.regDat_i(regDat_i),
		.attr(attr)
	);

	// one scanner per sprite, image load qualified by the sprite select
	for (genvar g = 0; g < NSPR; g++) begin : gScan
		sprScanner uScan (
			.vclk(vclk),
			.rst_i(rst_i),
			.hctr_i(hctr),
			.vctr_i(vctr),
			.hEdge_i(hEdge),
			.vEdge_i(vEdge),
			.attr(attr[g]),
			.imgWr_i(imgWr_i && (imgSpr_i == 5'(g))),
			.imgAdr_i(imgAdr_i),
			.imgDat_i(imgDat_i),
			.sprPix_o(sprPix[g]),
			.sprDe_o(sprDe[g])
		);
	end

	sprCompositor #(.NSPR(NSPR)) uComp (
		.vclk(vclk),
		.rst_i(rst_i),
		.sprPix_i(sprPix),
		.sprDe_i(sprDe),
		.attr(attr),
		.zrgb_i(zrgb_i),
		.blank_i(blank_i),
		.zrgb_o(zrgb_o)
	);

endmodule

`default_nettype wire

/* tbSpriteCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tbSpriteCtrl;
	import sprVideoPkg::*;
	import sprRegPkg::*;

	localparam int NSPR = 4;
	// small test frame, 64 dots by 40 lines
	localparam int LINE_DOTS = 64;
	localparam int FRAME_LINES = 40;
	localparam int FRAME_CYC = LINE_DOTS * FRAME_LINES;
	// sprites end well above this line, so it is safe to reprogram here
	localparam int WIN_LINE = 36;
	// one frame of setup, six test frames and a margin
	localparam int MAX_CYC = 6 * FRAME_CYC + FRAME_CYC + 512;

	logic vclk = 1'b0;
	logic rst_i;
	logic regWr_i;
	regAdr_t regAdr_i;
	regData_t regDat_i;
	logic imgWr_i;
	logic [4:0] imgSpr_i;
	imgAdr_t imgAdr_i;
	sprPixel_t imgDat_i;
	logic hsync_i;
	logic vsync_i;
	logic blank_i;
	zrgb_t zrgb_i;
	zrgb_t zrgb_o;

	// video generator position, dot being driven this cycle
	int dotCnt = 0;
	int lineCnt = 0;
	logic [31:0] rngState = 32'hbda7_a50f;
	// two random 8x6 images
	sprPixel_t srcImg [2][48];

	// model copies of registers and image memories
	hCount_t mHPos [NSPR];
	vCount_t mVPos [NSPR];
	sprDim_t mWidth [NSPR];
	sprDim_t mHeight [NSPR];
	pixRes_t mHRes [NSPR];
	pixRes_t mVRes [NSPR];
	plane_t mPlane [NSPR];
	tColor_t mTc [NSPR];
	logic [NSPR-1:0] mEn;
	sprPixel_t mImg [NSPR][256];
	// model reference counters and sync history
	hCount_t mHctr;
	vCount_t mVctr;
	logic mHsPrev;
	logic mVsPrev;
	// predictions waiting out the pipeline
	zrgb_t expQ [$];

	int errCount = 0;
	int shownCount = 0;
	int otherFails = 0;
	int errMark = 0;
	int shownMark = 0;
	int testNum = 0;
	int cycCount = 0;

	always #2 vclk = ~vclk;

	spriteCtrl #(.NSPR(NSPR)) UUT (
		.vclk(vclk),
		.rst_i(rst_i),
		.regWr_i(regWr_i),
		.regAdr_i(regAdr_i),
		.regDat_i(regDat_i),
		.imgWr_i(imgWr_i),
		.imgSpr_i(imgSpr_i),
		.imgAdr_i(imgAdr_i),
		.imgDat_i(imgDat_i),
		.hsync_i(hsync_i),
		.vsync_i(vsync_i),
		.blank_i(blank_i),
		.zrgb_i(zrgb_i),
		.zrgb_o(zrgb_o)
	);

	// --------------------
	// helpers
	// --------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// horizontal in 11:0, vertical in 27:16
	function automatic regData_t posWord(input int h, input int v);
		return {4'd0, 12'(v), 4'd0, 12'(h)};
	endfunction

	// sizes and scales are given as real counts, the register holds them minus one
	function automatic regData_t sizeWord(input int w, input int ht, input int hScale,
			input int vScale, input plane_t pl);
		return {4'd0, pl, 4'(vScale - 1), 4'(hScale - 1), 8'(ht - 1), 8'(w - 1)};
	endfunction

	// expected output for one dot, hit is set when a sprite reaches the output
	function automatic zrgb_t refPixel(input hCount_t h, input vCount_t v, input zrgb_t zin,
			input logic blank, output logic hit);
		int s;
		int hSpan;
		int vSpan;
		int col;
		int row;
		logic found;
		sprPixel_t cand;
		sprPixel_t winPix;
		plane_t winPlane;
		found = 1'b0;
		winPix = '0;
		winPlane = '0;
		hit = 1'b0;
		// sprite 0 is checked first and has the highest priority
		for (s = 0; s < NSPR; s++) begin
			hSpan = (int'(mWidth[s]) + 1) * (int'(mHRes[s]) + 1);
			vSpan = (int'(mHeight[s]) + 1) * (int'(mVRes[s]) + 1);
			if (!found && mEn[s] && int'(h) >= int'(mHPos[s]) && int'(h) < int'(mHPos[s]) + hSpan
					&& int'(v) >= int'(mVPos[s]) && int'(v) < int'(mVPos[s]) + vSpan) begin
				col = (int'(h) - int'(mHPos[s])) / (int'(mHRes[s]) + 1);
				row = (int'(v) - int'(mVPos[s])) / (int'(mVRes[s]) + 1);
				cand = mImg[s][8'(row * (int'(mWidth[s]) + 1) + col)];
				// bit 15 takes no part in the transparency test
				if (cand[14:0] != mTc[s]) begin
					found = 1'b1;
					winPix = cand;
					winPlane = mPlane[s];
				end
			end
		end
		if (blank)
			return '0;
		if (!found || zin[39:36] > winPlane)
			return zin;
		hit = 1'b1;
		// 5-bit colors go to the top of the 12-bit fields
		return {winPlane, winPix[14:10], 7'b0, winPix[9:5], 7'b0, winPix[4:0], 7'b0};
	endfunction

	task automatic checkValue(input zrgb_t got, input zrgb_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			errCount <= errCount + 1;
		end
	endtask

	// stops at the first dot of the reprogramming line
	task automatic waitWindow();
		@(posedge vclk);
		while (!(lineCnt == WIN_LINE && dotCnt == 0))
			@(posedge vclk);
	endtask

	task automatic regWrite(input regAdr_t adr, input regData_t dat);
		regWr_i <= 1'b1;
		regAdr_i <= adr;
		regDat_i <= dat;
		@(posedge vclk);
		regWr_i <= 1'b0;
	endtask

	task automatic loadImage(input int spr, input int src);
		for (int i = 0; i < 48; i++) begin
			imgWr_i <= 1'b1;
			imgSpr_i <= 5'(spr);
			imgAdr_i <= imgAdr_t'(i);
			imgDat_i <= srcImg[src][i];
			@(posedge vclk);
		end
		imgWr_i <= 1'b0;
	endtask

	// runs one frame, then reports it
	task automatic finishTest(input string name, input logic wantSprite);
		int errs;
		int shown;
		waitWindow();
		errs = errCount - errMark;
		shown = shownCount - shownMark;
		testNum++;
		$display("test %0d, %s: %0d mismatches, %0d sprite dots", testNum, name, errs, shown);
		if (wantSprite && shown == 0) begin
			$display("test %0d: no sprite pixel reached the output", testNum);
			otherFails++;
		end
		if (!wantSprite && shown != 0) begin
			$display("test %0d: sprite pixels were predicted where none belong", testNum);
			otherFails++;
		end
		errMark = errCount;
		shownMark = shownCount;
	endtask

	// --------------------
	// video stream
	// --------------------
	always @(posedge vclk) begin : video
		logic [31:0] r1;
		logic [31:0] r2;
		rngState = xorshift32(rngState);
		r1 = rngState;
		rngState = xorshift32(rngState);
		r2 = rngState;
		hsync_i <= (dotCnt < 4);
		vsync_i <= (lineCnt == 0) && (dotCnt < 4);
		blank_i <= (dotCnt >= 56);
		// random background, plane included
		zrgb_i <= {r1[7:0], r2};
		if (dotCnt == LINE_DOTS - 1) begin
			dotCnt <= 0;
			lineCnt <= (lineCnt == FRAME_LINES - 1) ? 0 : lineCnt + 1;
		end else begin
			dotCnt <= dotCnt + 1;
		end
	end

	// --------------------
	// model and compare
	// --------------------
	always @(posedge vclk) begin : compare
		zrgb_t expVal;
		logic hit;
		logic hRise;
		logic vRise;
		if (rst_i) begin
			expVal = '0;
			mHctr = '0;
			mVctr = '0;
			mHsPrev = 1'b0;
			mVsPrev = 1'b0;
			mEn = '0;
			for (int s = 0; s < NSPR; s++) begin
				mHPos[s] = '0;
				mVPos[s] = '0;
				mWidth[s] = '0;
				mHeight[s] = '0;
				mHRes[s] = '0;
				mVRes[s] = '0;
				mPlane[s] = '0;
				mTc[s] = '0;
			end
		end else begin
			// prediction for the dot present in this cycle
			expVal = refPixel(mHctr, mVctr, zrgb_i, blank_i, hit);
			if (hit)
				shownCount <= shownCount + 1;
			// reference counters from the sync edges
			hRise = hsync_i && !mHsPrev;
			vRise = vsync_i && !mVsPrev;
			mHsPrev = hsync_i;
			mVsPrev = vsync_i;
			if (hRise)
				mHctr = '0;
			else
				mHctr = mHctr + 1'b1;
			if (vRise)
				mVctr = '0;
			else if (hRise)
				mVctr = mVctr + 1'b1;
			// register writes take effect from the next cycle
			if (regWr_i) begin
				if (regAdr_i == REG_EN) begin
					for (int s = 0; s < NSPR; s++)
						mEn[s] = regDat_i[s];
				end else if (int'(regAdr_i[7:2]) < NSPR) begin
					case (regAdr_i[1:0])
						REG_POS: begin
							mHPos[regAdr_i[7:2]] = regDat_i[11:0];
							mVPos[regAdr_i[7:2]] = regDat_i[27:16];
						end
						REG_SIZE: begin
							mWidth[regAdr_i[7:2]] = regDat_i[7:0];
							mHeight[regAdr_i[7:2]] = regDat_i[15:8];
							mHRes[regAdr_i[7:2]] = regDat_i[19:16];
							mVRes[regAdr_i[7:2]] = regDat_i[23:20];
							mPlane[regAdr_i[7:2]] = regDat_i[27:24];
						end
						REG_TC: mTc[regAdr_i[7:2]] = regDat_i[14:0];
						default: ;
					endcase
				end
			end
			if (imgWr_i && int'(imgSpr_i) < NSPR)
				mImg[imgSpr_i][imgAdr_i] = imgDat_i;
		end
		expQ.push_back(expVal);
		if (expQ.size() > PIPE_DLY)
			checkValue(zrgb_o, expQ.pop_front(), "zrgb_o");
		cycCount++;
		if (cycCount >= MAX_CYC) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYC);
			$display(">>> FAIL");
			$finish;
		end
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		rst_i = 1'b1;
		regWr_i = 1'b0;
		regAdr_i = '0;
		regDat_i = '0;
		imgWr_i = 1'b0;
		imgSpr_i = '0;
		imgAdr_i = '0;
		imgDat_i = '0;
		hsync_i = 1'b0;
		vsync_i = 1'b0;
		blank_i = 1'b0;
		zrgb_i = '0;
		// images are drawn before the stream takes over the generator
		for (int k = 0; k < 2; k++) begin
			for (int i = 0; i < 48; i++) begin
				rngState = xorshift32(rngState);
				srcImg[k][i] = rngState[15:0];
			end
		end
		repeat (2) @(posedge vclk);
		rst_i <= 1'b0;
		waitWindow();

		// plain pass through, blank forces zero
		finishTest("no sprite enabled", 1'b0);

		// sprite 0, 8x6 at scale 1, above every input plane
		loadImage(0, 0);
		regWrite(regAdr_t'(4 * 0 + REG_POS), posWord(10, 4));
		regWrite(regAdr_t'(4 * 0 + REG_SIZE), sizeWord(8, 6, 1, 1, 4'd15));
		regWrite(REG_EN, 32'h1);
		finishTest("single 8x6 sprite", 1'b1);

		// key out a color that is in the image
		regWrite(regAdr_t'(4 * 0 + REG_TC), {17'd0, srcImg[0][5][14:0]});
		finishTest("transparent color", 1'b1);

		regWrite(REG_EN, 32'h0);
		finishTest("sprite disabled", 1'b0);

		// each pixel 2 dots wide and 3 lines high
		regWrite(regAdr_t'(4 * 0 + REG_SIZE), sizeWord(8, 6, 2, 3, 4'd15));
		regWrite(REG_EN, 32'h1);
		finishTest("stretched 2 x 3", 1'b1);

		// sprite 1 overlaps sprite 0, both on plane 7
		loadImage(1, 1);
		regWrite(regAdr_t'(4 * 0 + REG_SIZE), sizeWord(8, 6, 1, 1, 4'd7));
		regWrite(regAdr_t'(4 * 1 + REG_POS), posWord(14, 6));
		regWrite(regAdr_t'(4 * 1 + REG_SIZE), sizeWord(8, 6, 1, 1, 4'd7));
		regWrite(REG_EN, 32'h3);
		finishTest("overlap and plane", 1'b1);

		$display("%0d tests, %0d mismatches, %0d other failures", testNum, errCount, otherFails);
		if (errCount == 0 && otherFails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
